/* logic/alu.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module alu import corePkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  aluOpE            op,
  output logic [`XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       ltS;
  logic       ltU;

  assign shamt = b[4:0];
  assign ltS   = $signed(a) < $signed(b);
  assign ltU   = a < b;

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSll:   result = a << shamt;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $signed(a) >>> shamt;
      // compares give a 0/1 word, branches test for one
      aluSlt:   result = {{(`XLEN-1){1'b0}}, ltS};
      aluSltu:  result = {{(`XLEN-1){1'b0}}, ltU};
      aluEq:    result = {{(`XLEN-1){1'b0}}, a == b};
      aluNe:    result = {{(`XLEN-1){1'b0}}, a != b};
      aluGe:    result = {{(`XLEN-1){1'b0}}, !ltS};
      aluGeu:   result = {{(`XLEN-1){1'b0}}, !ltU};
      aluPassB: result = b;
      default:  result = '0;
    endcase
  end

endmodule

/* logic/corePkg.sv */
`include "core_macros.svh"

package corePkg;

  // one instruction word, six ways of slicing it
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFormatS;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFormatS;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } sFormatS;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } bFormatS;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uFormatS;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jFormatS;

  typedef union packed {
    rFormatS rFormat;
    iFormatS iFormat;
    sFormatS sFormat;
    bFormatS bFormat;
    uFormatS uFormat;
    jFormatS jFormat;
  } instrWord;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSll, aluSrl, aluSra,
    aluSlt, aluSltu, aluEq, aluNe, aluGe, aluGeu,
    aluPassB
  } aluOpE;

  typedef enum logic [1:0] {aSrcRs1, aSrcPc, aSrcZero} aSrcE;
  typedef enum logic [1:0] {bSrcRs2, bSrcImm, bSrcFour} bSrcE;

  // encoded as the load/store funct3
  typedef enum logic [2:0] {
    memByte  = 3'b000,
    memHalf  = 3'b001,
    memWord  = 3'b010,
    memByteU = 3'b100,
    memHalfU = 3'b101
  } memOpE;

  typedef struct packed {
    aSrcE  aSrc;
    bSrcE  bSrc;
    aluOpE aluOp;
    logic  memRead;
    logic  memWrite;
    memOpE memOp;
    logic  pcASrc;    // 0 pc, 1 rs1
    logic  pcBSrc;    // 0 four, 1 imm
    logic  branch;
    logic  regWrite;
    logic  wbFromMem;
    logic  ebreak;
  } ctrlSig;

  typedef struct packed {
    logic              valid;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  wbData;
    logic [`XLEN-1:0]  nextPc;
    logic              regWrite;
  } retireInfo;

endpackage

/* logic/coreTop.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTop import corePkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  instrWord         instr,
  output logic [`XLEN-1:0] pc,
  output retireInfo        retire,
  output logic             halt
);

  ctrlSig           ctrl;
  logic [`XLEN-1:0] imm;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [`XLEN-1:0] rs1Data;
  logic [`XLEN-1:0] rs2Data;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] nextPc;
  logic [`XLEN-1:0] loadData;
  logic [`XLEN-1:0] wbData;
  logic             regWriteEn;
  logic             memWriteEn;

  instFetch fetch0 (
    .clk    (clk),
    .rstN   (rstN),
    .nextPc (nextPc),
    .ebreak (ctrl.ebreak),
    .pc     (pc),
    .halt   (halt)
  );

  instDecode decode0 (
    .instr (instr),
    .ctrl  (ctrl),
    .imm   (imm),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd)
  );

  // once halted nothing architectural changes
  assign regWriteEn = ctrl.regWrite & ~halt;
  assign memWriteEn = ctrl.memWrite & ~halt;

  regFile regs0 (
    .clk       (clk),
    .rstN      (rstN),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .writeEn   (regWriteEn),
    .writeData (wbData),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data)
  );

  execUnit exec0 (
    .pc        (pc),
    .imm       (imm),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .ctrl      (ctrl),
    .aluResult (aluResult),
    .nextPc    (nextPc)
  );

  dataMem dmem0 (
    .clk       (clk),
    .addr      (aluResult),   // effective address comes from the ALU add
    .storeData (rs2Data),
    .memRead   (ctrl.memRead),
    .memWrite  (memWriteEn),
    .memOp     (ctrl.memOp),
    .loadData  (loadData)
  );

  assign wbData = ctrl.wbFromMem ? loadData : aluResult;

  // one instruction retires in every cycle out of reset until halt
  assign retire.valid    = rstN & ~halt;
  assign retire.rd       = rd;
  assign retire.wbData   = wbData;
  assign retire.nextPc   = nextPc;
  assign retire.regWrite = regWriteEn;

endmodule

/* logic/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// on-chip data memory, in 32-bit words
`define DMEM_WORDS 256

// architectural integer registers
`define REG_COUNT 32

`endif

/* logic/dataMem.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module dataMem import corePkg::*; (
  input  logic             clk,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] storeData,
  input  logic             memRead,
  input  logic             memWrite,
  input  memOpE            memOp,
  output logic [`XLEN-1:0] loadData
);

  logic [`XLEN-1:0] mem [`DMEM_WORDS];
  logic [$clog2(`DMEM_WORDS)-1:0] wordIdx;
  logic [4:0]       laneShift;
  logic [3:0]       byteMask;
  logic [`XLEN-1:0] laneData;
  logic [`XLEN-1:0] readWord;

  assign wordIdx   = addr[$clog2(`DMEM_WORDS)+1:2];  // upper bits wrap around
  assign laneShift = {addr[1:0], 3'b000};

  always_comb begin
    case (memOp)
      memByte, memByteU: byteMask = 4'b0001 << addr[1:0];
      memHalf, memHalfU: byteMask = 4'b0011 << addr[1:0];
      memWord:           byteMask = 4'b1111;
      default:           byteMask = 4'b0000;
    endcase
  end

  assign laneData = storeData << laneShift;   // move the low bytes into their lane

  always_ff @(posedge clk) begin
    if (memWrite) begin
      for (int k = 0; k < 4; k++) begin
        if (byteMask[k]) begin
          mem[wordIdx][8*k +: 8] <= laneData[8*k +: 8];
        end
      end
    end
  end

  assign readWord = mem[wordIdx] >> laneShift;

  always_comb begin
    if (!memRead) begin
      loadData = '0;
    end else begin
      case (memOp)
        memByte:  loadData = {{24{readWord[7]}}, readWord[7:0]};
        memHalf:  loadData = {{16{readWord[15]}}, readWord[15:0]};
        memByteU: loadData = {24'b0, readWord[7:0]};
        memHalfU: loadData = {16'b0, readWord[15:0]};
        default:  loadData = readWord;
      endcase
    end
  end

endmodule

/* logic/execUnit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module execUnit import corePkg::*; (
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] rs1Data,
  input  logic [`XLEN-1:0] rs2Data,
  input  ctrlSig           ctrl,
  output logic [`XLEN-1:0] aluResult,
  output logic [`XLEN-1:0] nextPc
);

  logic [`XLEN-1:0] aluA;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] pcA;
  logic [`XLEN-1:0] pcB;
  logic [`XLEN-1:0] pcSum;
  logic [`XLEN-1:0] pcDefault;

  always_comb begin
    case (ctrl.aSrc)
      aSrcRs1: aluA = rs1Data;
      aSrcPc:  aluA = pc;
      default: aluA = '0;
    endcase
  end

  always_comb begin
    case (ctrl.bSrc)
      bSrcRs2:  aluB = rs2Data;
      bSrcImm:  aluB = imm;
      bSrcFour: aluB = `XLEN'd4;
      default:  aluB = '0;
    endcase
  end

  alu alu0 (
    .a      (aluA),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult)
  );

  // jump target path, separate adder from the ALU
  assign pcA   = ctrl.pcASrc ? rs1Data : pc;
  assign pcB   = ctrl.pcBSrc ? imm : `XLEN'd4;
  assign pcSum = pcA + pcB;
  assign pcDefault = ctrl.pcASrc ? {pcSum[`XLEN-1:1], 1'b0} : pcSum;  // jalr drops bit 0

  // compare ops yield exactly one when the branch is taken
  assign nextPc = (ctrl.branch && aluResult == `XLEN'd1) ? pc + imm : pcDefault;

endmodule

/* logic/instDecode.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instDecode import corePkg::*; (
  input  instrWord         instr,
  output ctrlSig           ctrl,
  output logic [`XLEN-1:0] imm,
  output logic [4:0]       rs1,
  output logic [4:0]       rs2,
  output logic [4:0]       rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;

  assign opcode   = instr.rFormat.opcode;
  assign funct3   = instr.rFormat.funct3;
  assign funct7b5 = instr.rFormat.funct7[5];

  assign rs1 = instr.rFormat.rs1;
  assign rs2 = instr.rFormat.rs2;
  assign rd  = instr.rFormat.rd;

  // shared by OP and OP-IMM, alt picks sub/sra
  function automatic aluOpE opFromFunct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  opFromFunct3 = alt ? aluSub : aluAdd;
      3'b001:  opFromFunct3 = aluSll;
      3'b010:  opFromFunct3 = aluSlt;
      3'b011:  opFromFunct3 = aluSltu;
      3'b100:  opFromFunct3 = aluXor;
      3'b101:  opFromFunct3 = alt ? aluSra : aluSrl;
      3'b110:  opFromFunct3 = aluOr;
      default: opFromFunct3 = aluAnd;
    endcase
  endfunction

  always_comb begin
    ctrl       = '0;       // unknown opcodes fall through as a no-op
    ctrl.aSrc  = aSrcZero;
    ctrl.bSrc  = bSrcImm;
    ctrl.aluOp = aluAdd;
    ctrl.memOp = memWord;
    imm        = '0;
    case (opcode)
      7'b0110011: begin  // OP
        ctrl.aSrc     = aSrcRs1;
        ctrl.bSrc     = bSrcRs2;
        ctrl.aluOp    = opFromFunct3(funct3, funct7b5);
        ctrl.regWrite = 1'b1;
      end
      7'b0010011: begin  // OP-IMM, only the shifts look at funct7
        ctrl.aSrc     = aSrcRs1;
        ctrl.aluOp    = opFromFunct3(funct3, funct7b5 && funct3 == 3'b101);
        ctrl.regWrite = 1'b1;
        imm = {{20{instr.iFormat.imm11_0[11]}}, instr.iFormat.imm11_0};
      end
      7'b0000011: begin  // loads
        ctrl.aSrc      = aSrcRs1;
        ctrl.memRead   = 1'b1;
        ctrl.memOp     = memOpE'(funct3);
        ctrl.regWrite  = 1'b1;
        ctrl.wbFromMem = 1'b1;
        imm = {{20{instr.iFormat.imm11_0[11]}}, instr.iFormat.imm11_0};
      end
      7'b0100011: begin  // stores
        ctrl.aSrc     = aSrcRs1;
        ctrl.memWrite = 1'b1;
        ctrl.memOp    = memOpE'(funct3);
        imm = {{20{instr.sFormat.imm11_5[6]}}, instr.sFormat.imm11_5,
               instr.sFormat.imm4_0};
      end
      7'b1100011: begin  // branches compare rs1 against rs2
        ctrl.aSrc   = aSrcRs1;
        ctrl.bSrc   = bSrcRs2;
        ctrl.branch = 1'b1;
        case (funct3)
          3'b000:  ctrl.aluOp = aluEq;
          3'b001:  ctrl.aluOp = aluNe;
          3'b100:  ctrl.aluOp = aluSlt;
          3'b101:  ctrl.aluOp = aluGe;
          3'b110:  ctrl.aluOp = aluSltu;
          default: ctrl.aluOp = aluGeu;
        endcase
        imm = {{19{instr.bFormat.imm12}}, instr.bFormat.imm12, instr.bFormat.imm11,
               instr.bFormat.imm10_5, instr.bFormat.imm4_1, 1'b0};
      end
      7'b0110111: begin  // lui
        ctrl.aluOp    = aluPassB;
        ctrl.regWrite = 1'b1;
        imm = {instr.uFormat.imm31_12, 12'b0};
      end
      7'b0010111: begin  // auipc
        ctrl.aSrc     = aSrcPc;
        ctrl.regWrite = 1'b1;
        imm = {instr.uFormat.imm31_12, 12'b0};
      end
      7'b1101111: begin  // jal, link value is pc + 4
        ctrl.aSrc     = aSrcPc;
        ctrl.bSrc     = bSrcFour;
        ctrl.pcBSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        imm = {{11{instr.jFormat.imm20}}, instr.jFormat.imm20, instr.jFormat.imm19_12,
               instr.jFormat.imm11, instr.jFormat.imm10_1, 1'b0};
      end
      7'b1100111: begin  // jalr
        ctrl.aSrc     = aSrcPc;
        ctrl.bSrc     = bSrcFour;
        ctrl.pcASrc   = 1'b1;
        ctrl.pcBSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        imm = {{20{instr.iFormat.imm11_0[11]}}, instr.iFormat.imm11_0};
      end
      7'b1110011: begin
        ctrl.ebreak = (instr.iFormat.imm11_0 == 12'd1) && (funct3 == 3'b000);
      end
      default: ;
    endcase
  end

endmodule

/* logic/instFetch.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instFetch (
  input  logic             clk,
  input  logic             rstN,
  input  logic [`XLEN-1:0] nextPc,
  input  logic             ebreak,
  output logic [`XLEN-1:0] pc,
  output logic             halt
);

  // pc advances every cycle; the halt flag freezes it for good
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc   <= `RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      pc   <= nextPc;
      halt <= ebreak;   // sticky until reset
    end
  end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  logic [4:0]       rd,
  input  logic             writeEn,
  input  logic [`XLEN-1:0] writeData,
  output logic [`XLEN-1:0] rs1Data,
  output logic [`XLEN-1:0] rs2Data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && rd != 5'd0) begin  // x0 never written
      regs[rd] <= writeData;
    end
  end

  // reads see the old value during a same-cycle write
  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

endmodule

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

/* sim.f */
+incdir+logic
logic/corePkg.sv
logic/alu.sv
logic/instFetch.sv
logic/instDecode.sv
logic/regFile.sv
logic/execUnit.sv
logic/dataMem.sv
logic/coreTop.sv
tests/clockGen.sv
tests/coreChecker.sv
tests/coreTb.sv

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

endmodule

/* tests/coreChecker.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module coreChecker import corePkg::*; (
  input  logic             clk,
  input  logic [`XLEN-1:0] pc,
  input  retireInfo        retire,
  input  logic             halt,
  input  logic             expWe,
  input  logic [4:0]       expRd,
  input  logic [`XLEN-1:0] expWb,
  input  logic [`XLEN-1:0] expNext,
  input  logic [95:0]      testName,
  input  logic             endRun,
  output int               errCount
);

  int               errs = 0;
  int               passCount = 0;
  logic             seenRetire = 1'b0;
  logic             haltSeen = 1'b0;
  logic             haltBad = 1'b0;
  logic [`XLEN-1:0] frozenPc;

  assign errCount = errs;

  // rd and wbData only matter when the row writes a register
  task automatic checkRow();
    logic ok;
    ok = (retire.nextPc == expNext) && (retire.regWrite == expWe);
    if (expWe) begin
      ok = ok && (retire.rd == expRd) && (retire.wbData == expWb);
    end
    if (ok) begin
      passCount++;
      $display("pass %s", testName);
    end else begin
      errs++;
      $write("** Error %s: expected we %b rd %0d wb %h next %h,", testName,
             expWe, expRd, expWb, expNext);
      $display(" actual we %b rd %0d wb %h next %h", retire.regWrite,
               retire.rd, retire.wbData, retire.nextPc);
    end
  endtask

  always @(posedge clk) begin
    if (retire.valid) begin
      if (!seenRetire) begin
        if (pc == `RESET_PC) begin
          passCount++;
          $display("pass reset pc");
        end else begin
          errs++;
          $display("** Error reset pc: expected %h actual %h", `RESET_PC, pc);
        end
        seenRetire = 1'b1;
      end
      checkRow();
    end
    if (halt) begin
      if (!haltSeen) begin
        frozenPc = pc;   // first halted cycle
        haltSeen = 1'b1;
      end else if (pc != frozenPc && !haltBad) begin
        errs++;
        haltBad = 1'b1;
        $display("** Error halt hold: pc expected %h actual %h", frozenPc, pc);
      end
      if (retire.valid && !haltBad) begin
        errs++;
        haltBad = 1'b1;
        $display("halt hold failed: an instruction retired while the core was halted");
      end
    end
  end

  always @(posedge endRun) begin
    if (!haltSeen) begin
      errs++;
      $display("halt failed: the core never raised halt");
    end else if (!haltBad) begin
      passCount++;
      $display("pass halt hold");
    end
    $display("tests passed %0d, errors %0d", passCount, errs);
  end

endmodule

/* tests/coreTb.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTb import corePkg::*; ();

  localparam int ROWS = 64;
  localparam int CYCLE_LIMIT = 200;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LOAD = 7'b0000011;
  localparam logic [6:0] LUI = 7'b0110111;
  localparam logic [6:0] AUIPC = 7'b0010111;
  localparam logic [6:0] JALR = 7'b1100111;
  localparam logic [6:0] SYSTEM = 7'b1110011;
  localparam logic [31:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

  logic             clk;
  logic             rstN;
  instrWord         instr;
  logic [`XLEN-1:0] pc;
  retireInfo        retire;
  logic             halt;
  logic             endRun;
  logic [5:0]       rowIdx;
  int               checkErrs;
  int               timeouts;
  int               cyc;
  int               nRows;
  int               seed;
  logic [31:0]      valA;
  logic [31:0]      valB;
  logic [31:0]      hiA;
  logic [31:0]      hiB;
  logic [31:0]      mword;

  // program table with one row per instruction slot
  logic [31:0] instrTab [ROWS];
  logic        weTab [ROWS];
  logic [4:0]  rdTab [ROWS];
  logic [31:0] wbTab [ROWS];
  logic [31:0] nextTab [ROWS];
  logic [95:0] nameTab [ROWS];

  clockGen clkGen0 (.clk(clk));

  coreTop UUT (
    .clk    (clk),
    .rstN   (rstN),
    .instr  (instr),
    .pc     (pc),
    .retire (retire),
    .halt   (halt)
  );

  assign rowIdx = pc[7:2];

  coreChecker check0 (
    .clk      (clk),
    .pc       (pc),
    .retire   (retire),
    .halt     (halt),
    .expWe    (weTab[rowIdx]),
    .expRd    (rdTab[rowIdx]),
    .expWb    (wbTab[rowIdx]),
    .expNext  (nextTab[rowIdx]),
    .testName (nameTab[rowIdx]),
    .endRun   (endRun),
    .errCount (checkErrs)
  );

  function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, rs1, f3, rd);
    rType = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input int imm, rs1, f3, rd, input logic [6:0] op);
    iType = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] sType(input int imm, rs2, rs1, f3);
    sType = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bType(input int imm, rs2, rs1, f3);
    bType = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] uType(input int imm20, rd, input logic [6:0] op);
    uType = {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] jType(input int imm, rd);
    jType = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] here();
    here = nRows * 4;   // pc of the row being added
  endfunction

  task automatic addRow(input logic [31:0] ins, input logic we, input int rd,
                        input logic [31:0] wb, next, input logic [95:0] name);
    instrTab[nRows] = ins;
    weTab[nRows] = we;
    rdTab[nRows] = rd[4:0];
    wbTab[nRows] = wb;
    nextTab[nRows] = next;
    nameTab[nRows] = name;
    nRows++;
  endtask

  task automatic buildProgram();
    logic [31:0] link;
    int          jImm;
    valA = $random(seed);
    valB = $random(seed);
    hiA = (valA + 32'h800) >> 12;  // rounded so lui plus the signed addi gives back valA
    hiB = (valB + 32'h800) >> 12;
    nRows = 0;
    addRow(uType(hiA, 1, LUI), 1'b1, 1, {hiA[19:0], 12'h000}, here() + 4, "lui x1");
    addRow(iType(valA, 1, 0, 1, OP_IMM), 1'b1, 1, valA, here() + 4, "addi x1");
    addRow(uType(hiB, 2, LUI), 1'b1, 2, {hiB[19:0], 12'h000}, here() + 4, "lui x2");
    addRow(iType(valB, 2, 0, 2, OP_IMM), 1'b1, 2, valB, here() + 4, "addi x2");
    addRow(rType(7'h00, 2, 1, 0, 3), 1'b1, 3, valA + valB, here() + 4, "add");
    addRow(rType(7'h20, 2, 1, 0, 4), 1'b1, 4, valA - valB, here() + 4, "sub");
    addRow(rType(7'h00, 2, 1, 7, 5), 1'b1, 5, valA & valB, here() + 4, "and");
    addRow(rType(7'h00, 2, 1, 6, 6), 1'b1, 6, valA | valB, here() + 4, "or");
    addRow(rType(7'h00, 2, 1, 4, 7), 1'b1, 7, valA ^ valB, here() + 4, "xor");
    addRow(rType(7'h00, 2, 1, 1, 8), 1'b1, 8, valA << valB[4:0], here() + 4, "sll");
    addRow(rType(7'h00, 2, 1, 5, 9), 1'b1, 9, valA >> valB[4:0], here() + 4, "srl");
    addRow(rType(7'h20, 2, 1, 5, 10), 1'b1, 10, $signed(valA) >>> valB[4:0], here() + 4, "sra");
    addRow(rType(7'h00, 2, 1, 2, 11), 1'b1, 11, {31'b0, $signed(valA) < $signed(valB)},
           here() + 4, "slt");
    addRow(rType(7'h00, 2, 1, 3, 12), 1'b1, 12, {31'b0, valA < valB}, here() + 4, "sltu");
    addRow(iType(-5, 1, 0, 13, OP_IMM), 1'b1, 13, valA - 32'd5, here() + 4, "addi neg");
    addRow(iType('h5a5, 1, 4, 14, OP_IMM), 1'b1, 14, valA ^ 32'h5a5, here() + 4, "xori");
    addRow(iType('h407, 1, 5, 15, OP_IMM), 1'b1, 15, $signed(valA) >>> 7, here() + 4, "srai");
    addRow(iType(3, 2, 1, 16, OP_IMM), 1'b1, 16, valB << 3, here() + 4, "slli");
    addRow(iType(-1, 1, 3, 17, OP_IMM), 1'b1, 17, {31'b0, valA < 32'hffff_ffff},
           here() + 4, "sltiu");
    addRow(iType(1, 1, 0, 0, OP_IMM), 1'b1, 0, valA + 32'd1, here() + 4, "addi x0");
    addRow(rType(7'h00, 0, 0, 0, 18), 1'b1, 18, 32'd0, here() + 4, "x0 is zero");
    addRow(uType('h12345, 19, AUIPC), 1'b1, 19, here() + 32'h1234_5000, here() + 4, "auipc");
    link = here() + 4;
    addRow(jType(8, 20), 1'b1, 20, here() + 4, here() + 8, "jal");
    addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    jImm = here() + 8 - link + 1;   // odd target so jalr must clear bit 0
    addRow(iType(jImm, 20, 0, 21, JALR), 1'b1, 21, here() + 4, (link + jImm) & ~32'd1, "jalr");
    addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    addRow(bType(8, 1, 1, 0), 1'b0, 0, 32'd0, here() + 8, "beq taken");
    addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    addRow(bType(8, 1, 1, 1), 1'b0, 0, 32'd0, here() + 4, "bne fall");
    addRow(bType(8, 2, 1, 4), 1'b0, 0, 32'd0,
           ($signed(valA) < $signed(valB)) ? here() + 8 : here() + 4, "blt");
    addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    addRow(bType(8, 2, 1, 7), 1'b0, 0, 32'd0, (valA >= valB) ? here() + 8 : here() + 4, "bgeu");
    addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    addRow(iType(64, 0, 0, 22, OP_IMM), 1'b1, 22, 32'd64, here() + 4, "base addr");
    addRow(sType(0, 1, 22, 2), 1'b0, 0, 32'd0, here() + 4, "sw");
    addRow(sType(1, 2, 22, 0), 1'b0, 0, 32'd0, here() + 4, "sb");
    addRow(sType(2, 2, 22, 1), 1'b0, 0, 32'd0, here() + 4, "sh");
    mword = {valB[15:0], valB[7:0], valA[7:0]};   // word after the three stores
    addRow(iType(0, 22, 2, 23, LOAD), 1'b1, 23, mword, here() + 4, "lw");
    addRow(iType(1, 22, 0, 24, LOAD), 1'b1, 24, {{24{mword[15]}}, mword[15:8]}, here() + 4, "lb");
    addRow(iType(1, 22, 4, 25, LOAD), 1'b1, 25, {24'h0, mword[15:8]}, here() + 4, "lbu");
    addRow(iType(2, 22, 1, 26, LOAD), 1'b1, 26, {{16{mword[31]}}, mword[31:16]}, here() + 4,
           "lh");
    addRow(iType(2, 22, 5, 27, LOAD), 1'b1, 27, {16'h0, mword[31:16]}, here() + 4, "lhu");
    addRow(iType(1, 0, 0, 0, SYSTEM), 1'b0, 0, 32'd0, here() + 4, "ebreak");
    while (nRows < ROWS) begin
      addRow(NOP, 1'b1, 0, 32'd0, here() + 4, "nop");
    end
  endtask

  initial begin
    seed = 74652;
    timeouts = 0;
    endRun = 1'b0;
    rstN = 1'b0;
    instr = '0;
    buildProgram();
    instr = instrTab[0];
    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;
    cyc = 0;
    while (!halt && cyc < CYCLE_LIMIT) begin
      @(posedge clk);
      #1 instr = instrTab[rowIdx];   // fetch for the new pc
      cyc++;
    end
    if (!halt) begin
      timeouts++;
      $display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
    end else begin
      for (cyc = 0; cyc < 10; cyc++) begin
        @(posedge clk);
        #1 instr = instrTab[rowIdx];
      end
    end
    endRun = 1'b1;
    #1;
    if (checkErrs == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
